// ==== logic/bus_defs.svh ====
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// two harts, each with an instruction and a data port
`define NUM_REQUESTERS 4

`define ADDR_W 6         // word address
`define DATA_W 32
`define FIFO_DEPTH 4
`define MEM_DEPTH (1 << `ADDR_W)
`define MEM_LATENCY 3    // cycles per memory access

`endif

// ==== logic/bus_types_pkg.sv ====
`include "bus_defs.svh"

package bus_types_pkg;

    // one data word on the bus and in the backing memory
    typedef logic [`DATA_W-1:0] word_t;

    // word address, so the memory has 2**ADDR_W entries
    typedef logic [`ADDR_W-1:0] addr_t;

    // index of the requester that issued a request
    typedef logic [$clog2(`NUM_REQUESTERS)-1:0] req_id_t;

    // credit counter, must hold the full FIFO depth
    typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] credit_t;

endpackage

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // single-word bus operation
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_t;

    // memory controller FSM
    typedef enum logic [1:0] {
        mc_idle    = 2'd0,    // waiting for a request
        mc_access  = 2'd1,    // counting out the access latency
        mc_respond = 2'd2     // response and credit return
    } mc_state_t;

endpackage

// ==== logic/req_link_if.sv ====
`timescale 1ns/1ns

// one request per valid cycle, flow controlled by credits
interface req_link_if;

    logic                   valid;
    ctrl_pkg::bus_op_t      op;
    bus_types_pkg::addr_t   addr;
    bus_types_pkg::word_t   wdata;
    bus_types_pkg::req_id_t id;
    logic                   credit;    // one pulse per freed slot

    modport sender (
        output valid,
        output op,
        output addr,
        output wdata,
        output id,
        input  credit
    );

    modport receiver (
        input  valid,
        input  op,
        input  addr,
        input  wdata,
        input  id,
        output credit
    );

endinterface

// ==== logic/request_arbiter.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module request_arbiter (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic [`NUM_REQUESTERS-1:0]  req_valid,
    input  logic [`NUM_REQUESTERS-1:0]  req_write,
    input  bus_types_pkg::addr_t        req_addr [`NUM_REQUESTERS],
    input  bus_types_pkg::word_t        req_wdata [`NUM_REQUESTERS],
    output logic [`NUM_REQUESTERS-1:0]  req_ready,
    req_link_if.sender                  link
);

    bus_types_pkg::req_id_t prio_ptr;     // first index searched this cycle
    bus_types_pkg::req_id_t grant_idx;
    bus_types_pkg::credit_t credits;      // free slots in the request FIFO
    logic                   found;
    logic                   grant;

    // round-robin search starting at prio_ptr
    always_comb begin
        grant_idx = prio_ptr;
        found = 1'b0;
        for (int i = 0; i < `NUM_REQUESTERS; i++) begin
            if (!found && req_valid[(int'(prio_ptr) + i) % `NUM_REQUESTERS]) begin
                grant_idx = bus_types_pkg::req_id_t'((int'(prio_ptr) + i) % `NUM_REQUESTERS);
                found = 1'b1;
            end
        end
    end

    assign grant = found && (credits != '0);    // no credit, nobody is ready

    always_comb begin
        req_ready = '0;
        if (grant) begin
            req_ready[grant_idx] = 1'b1;
        end
    end

    assign link.valid = grant;
    assign link.op    = req_write[grant_idx] ? ctrl_pkg::op_write : ctrl_pkg::op_read;
    assign link.addr  = req_addr[grant_idx];
    assign link.wdata = req_wdata[grant_idx];
    assign link.id    = grant_idx;

    // next search starts one past the winner
    always_ff @(posedge CLK) begin
        if (reset) begin
            prio_ptr <= '0;
        end else if (grant) begin
            prio_ptr <= bus_types_pkg::req_id_t'((int'(grant_idx) + 1) % `NUM_REQUESTERS);
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            credits <= bus_types_pkg::credit_t'(`FIFO_DEPTH);
        end else begin
            case ({grant, link.credit})
                2'b10:   credits <= credits - 1'b1;    // spent on a grant
                2'b01:   credits <= credits + 1'b1;    // slot freed downstream
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== logic/request_fifo.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module request_fifo (
    input  logic          CLK,
    input  logic          reset,
    req_link_if.receiver  in_link,
    req_link_if.sender    out_link
);

    localparam int ptr_w = $clog2(`FIFO_DEPTH);
    localparam bus_types_pkg::credit_t mc_slots = 1;    // controller holds one request

    ctrl_pkg::bus_op_t      op_mem    [`FIFO_DEPTH];
    bus_types_pkg::addr_t   addr_mem  [`FIFO_DEPTH];
    bus_types_pkg::word_t   wdata_mem [`FIFO_DEPTH];
    bus_types_pkg::req_id_t id_mem    [`FIFO_DEPTH];

    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    bus_types_pkg::credit_t count;
    bus_types_pkg::credit_t out_credits;
    logic                   push;
    logic                   pop;

    assign push = in_link.valid;    // upstream credits keep this from overflowing
    assign pop  = (count != '0) && (out_credits != '0);

    always_ff @(posedge CLK) begin
        if (push) begin
            op_mem[wr_ptr]    <= in_link.op;
            addr_mem[wr_ptr]  <= in_link.addr;
            wdata_mem[wr_ptr] <= in_link.wdata;
            id_mem[wr_ptr]    <= in_link.id;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            count       <= '0;
            out_credits <= mc_slots;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pop, out_link.credit})
                2'b10:   out_credits <= out_credits - 1'b1;
                2'b01:   out_credits <= out_credits + 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    assign out_link.valid = pop;
    assign out_link.op    = op_mem[rd_ptr];
    assign out_link.addr  = addr_mem[rd_ptr];
    assign out_link.wdata = wdata_mem[rd_ptr];
    assign out_link.id    = id_mem[rd_ptr];

    assign in_link.credit = pop;    // the popped slot is free again

endmodule

// ==== logic/memory_controller.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module memory_controller (
    input  logic                    CLK,
    input  logic                    reset,
    req_link_if.receiver            link,
    output logic                    resp_valid,
    output bus_types_pkg::req_id_t  resp_id,
    output bus_types_pkg::word_t    resp_rdata
);

    localparam int cnt_w = $clog2(`MEM_LATENCY + 1);

    ctrl_pkg::mc_state_t    state;
    ctrl_pkg::mc_state_t    state_next;
    logic [cnt_w-1:0]       lat_cnt;
    logic                   access_done;

    ctrl_pkg::bus_op_t      op_q;
    bus_types_pkg::addr_t   addr_q;
    bus_types_pkg::word_t   wdata_q;
    bus_types_pkg::req_id_t id_q;
    bus_types_pkg::word_t   rdata_q;

    bus_types_pkg::word_t   mem [`MEM_DEPTH];

    // last cycle of the access phase
    assign access_done = (state == ctrl_pkg::mc_access) &&
                         (lat_cnt == cnt_w'(`MEM_LATENCY - 1));

    always_comb begin
        state_next = state;
        case (state)
            ctrl_pkg::mc_idle: begin
                if (link.valid) begin
                    state_next = ctrl_pkg::mc_access;
                end
            end
            ctrl_pkg::mc_access: begin
                if (access_done) begin
                    state_next = ctrl_pkg::mc_respond;
                end
            end
            ctrl_pkg::mc_respond: state_next = ctrl_pkg::mc_idle;
            default:              state_next = ctrl_pkg::mc_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state   <= ctrl_pkg::mc_idle;
            lat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == ctrl_pkg::mc_access && !access_done) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
        end
    end

    // request is only taken in idle, the single credit guarantees that
    always_ff @(posedge CLK) begin
        if (state == ctrl_pkg::mc_idle && link.valid) begin
            op_q    <= link.op;
            addr_q  <= link.addr;
            wdata_q <= link.wdata;
            id_q    <= link.id;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (access_done && op_q == ctrl_pkg::op_write) begin
            mem[addr_q] <= wdata_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (access_done) begin
            rdata_q <= (op_q == ctrl_pkg::op_write) ? '0 : mem[addr_q];    // writes answer zero
        end
    end

    assign resp_valid  = (state == ctrl_pkg::mc_respond);
    assign resp_id     = id_q;
    assign resp_rdata  = rdata_q;
    assign link.credit = resp_valid;    // ready for the next request

endmodule

// ==== logic/multicore_bus_top.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module multicore_bus_top (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic [`NUM_REQUESTERS-1:0]  req_valid,
    input  logic [`NUM_REQUESTERS-1:0]  req_write,
    input  bus_types_pkg::addr_t        req_addr [`NUM_REQUESTERS],
    input  bus_types_pkg::word_t        req_wdata [`NUM_REQUESTERS],
    output logic [`NUM_REQUESTERS-1:0]  req_ready,
    output logic                        resp_valid,
    output bus_types_pkg::req_id_t      resp_id,
    output bus_types_pkg::word_t        resp_rdata
);

    req_link_if arb_link ();    // arbiter to queue, FIFO_DEPTH credits
    req_link_if mc_link ();     // queue to controller, one credit

    request_arbiter arb_i (
        .CLK       (CLK),
        .reset     (reset),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .link      (arb_link.sender)
    );

    request_fifo fifo_i (
        .CLK      (CLK),
        .reset    (reset),
        .in_link  (arb_link.receiver),
        .out_link (mc_link.sender)
    );

    memory_controller mc_i (
        .CLK        (CLK),
        .reset      (reset),
        .link       (mc_link.receiver),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_rdata (resp_rdata)
    );

endmodule

// ==== verif/bus_chk.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module bus_chk (
    input logic                        CLK,
    input logic                        reset,
    input bus_types_pkg::credit_t      credits,
    input bus_types_pkg::credit_t      capacity,
    input logic                        link_valid,
    input logic                        link_credit,
    input logic [`NUM_REQUESTERS-1:0]  ready
);

    int assert_fails = 0;    // summed by the testbench at the end of the run
    bus_types_pkg::credit_t held;    // credits rebuilt from the link pulses alone

    always_ff @(posedge CLK) begin
        if (reset) begin
            held <= capacity;
        end else begin
            held <= held - bus_types_pkg::credit_t'(link_valid)
                         + bus_types_pkg::credit_t'(link_credit);
        end
    end

    credit_bound: assert property (@(posedge CLK) disable iff (reset) credits <= capacity)
        else begin
            $error("credit count %0d above capacity %0d", credits, capacity);
            assert_fails++;
        end

    valid_needs_credit: assert property (@(posedge CLK) disable iff (reset)
        link_valid |-> held != '0)
        else begin
            $error("link valid while no credit is held");
            assert_fails++;
        end

    one_ready: assert property (@(posedge CLK) disable iff (reset) $onehot0(ready))
        else begin
            $error("more than one req_ready bit high: %b", ready);
            assert_fails++;
        end

endmodule

bind request_arbiter bus_chk arb_chk_i (
    .CLK         (CLK),
    .reset       (reset),
    .credits     (credits),
    .capacity    (bus_types_pkg::credit_t'(`FIFO_DEPTH)),
    .link_valid  (link.valid),
    .link_credit (link.credit),
    .ready       (req_ready)
);

bind request_fifo bus_chk fifo_chk_i (
    .CLK         (CLK),
    .reset       (reset),
    .credits     (out_credits),
    .capacity    (bus_types_pkg::credit_t'(1)),
    .link_valid  (out_link.valid),
    .link_credit (out_link.credit),
    .ready       ('0)
);

// ==== verif/bus_monitor.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module bus_monitor (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic [`NUM_REQUESTERS-1:0]  req_valid,
    input  logic [`NUM_REQUESTERS-1:0]  req_write,
    input  bus_types_pkg::addr_t        req_addr [`NUM_REQUESTERS],
    input  bus_types_pkg::word_t        req_wdata [`NUM_REQUESTERS],
    input  logic [127:0]                req_name [`NUM_REQUESTERS],
    input  logic [`NUM_REQUESTERS-1:0]  req_ready,
    input  logic                        resp_valid,
    input  bus_types_pkg::req_id_t      resp_id,
    input  bus_types_pkg::word_t        resp_rdata,
    input  logic                        done,
    output int                          tests_done,
    output int                          errors
);

    bus_types_pkg::word_t ref_mem [`MEM_DEPTH];
    int                   exp_id_q [$];      // one entry per grant, oldest first
    bus_types_pkg::word_t exp_data_q [$];
    logic [127:0]         name_q [$];
    int                   rr_ptr;
    int                   passes;
    logic                 summary_done;

    // requester that round-robin should pick, starting the search at start
    function automatic int next_in_turn(input logic [`NUM_REQUESTERS-1:0] valid, input int start);
        int idx;
        idx = -1;
        for (int i = 0; i < `NUM_REQUESTERS; i++) begin
            if (idx < 0 && valid[(start + i) % `NUM_REQUESTERS]) begin
                idx = (start + i) % `NUM_REQUESTERS;
            end
        end
        return idx;
    endfunction

    always @(posedge CLK) begin
        int gnt;
        int exp_gnt;
        int exp_id;
        bus_types_pkg::word_t exp_data;
        logic [127:0] name;
        if (reset) begin
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                ref_mem[i] = '0;
            end
            exp_id_q.delete();
            exp_data_q.delete();
            name_q.delete();
            rr_ptr = 0;
            passes = 0;
            tests_done = 0;
            errors = 0;
            summary_done = 1'b0;
        end else begin
            if ((req_ready & ~req_valid) != '0) begin
                $display("req_ready %b raised for a requester that is not requesting", req_ready);
                errors++;
            end
            if (req_ready != '0) begin
                gnt = -1;
                for (int i = 0; i < `NUM_REQUESTERS; i++) begin
                    if (gnt < 0 && req_ready[i]) gnt = i;
                end
                exp_gnt = next_in_turn(req_valid, rr_ptr);
                if (gnt != exp_gnt) begin
                    $display("[FAIL] %0s grant expected requester %0d actual %0d",
                             req_name[gnt], exp_gnt, gnt);
                    errors++;
                end
                rr_ptr = (gnt + 1) % `NUM_REQUESTERS;
                exp_id_q.push_back(gnt);
                name_q.push_back(req_name[gnt]);
                if (req_write[gnt]) begin
                    ref_mem[req_addr[gnt]] = req_wdata[gnt];
                    exp_data_q.push_back('0);    // writes answer zero
                end else begin
                    exp_data_q.push_back(ref_mem[req_addr[gnt]]);
                end
            end
            if (resp_valid) begin
                if (exp_id_q.size() == 0) begin
                    $display("response from requester %0d arrived with no request outstanding",
                             resp_id);
                    errors++;
                end else begin
                    exp_id = exp_id_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    name = name_q.pop_front();
                    tests_done++;
                    if (exp_id == int'(resp_id) && exp_data == resp_rdata) begin
                        $display("[PASS] %0s id=%0d rdata=%h", name, resp_id, resp_rdata);
                        passes++;
                    end else begin
                        $display("[FAIL] %0s expected id=%0d rdata=%h actual id=%0d rdata=%h",
                                 name, exp_id, exp_data, resp_id, resp_rdata);
                        errors++;
                    end
                end
            end
            if (done && !summary_done) begin
                $display("summary: %0d tests checked, %0d passed, %0d errors",
                         tests_done, passes, errors);
                summary_done = 1'b1;
            end
        end
    end

endmodule

// ==== verif/bus_tb.sv ====
`timescale 1ns/1ns
`include "bus_defs.svh"

module bus_tb;

    localparam int num_tests = 30;
    localparam int cycle_limit = num_tests * `NUM_REQUESTERS * (`MEM_LATENCY + 4) + 100;

    logic                        CLK;
    logic                        reset;
    logic [`NUM_REQUESTERS-1:0]  req_valid;
    logic [`NUM_REQUESTERS-1:0]  req_write;
    bus_types_pkg::addr_t        req_addr [`NUM_REQUESTERS];
    bus_types_pkg::word_t        req_wdata [`NUM_REQUESTERS];
    logic [127:0]                req_name [`NUM_REQUESTERS];
    logic [`NUM_REQUESTERS-1:0]  req_ready;
    logic                        resp_valid;
    bus_types_pkg::req_id_t      resp_id;
    bus_types_pkg::word_t        resp_rdata;
    logic                        done;
    int                          tests_done;
    int                          errors;
    int                          grant_count;
    int                          resp_count;
    int                          cycle_count;

    // stimulus table
    logic [127:0]         t_name [num_tests];
    int                   t_req [num_tests];
    logic                 t_write [num_tests];
    bus_types_pkg::addr_t t_addr [num_tests];
    bus_types_pkg::word_t t_wdata [num_tests];
    int                   t_group [num_tests];
    int                   n_entries;
    int                   n_groups;

    multicore_bus_top dut_i (
        .CLK        (CLK),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_rdata (resp_rdata)
    );

    bus_monitor mon_i (
        .CLK        (CLK),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_name   (req_name),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_id    (resp_id),
        .resp_rdata (resp_rdata),
        .done       (done),
        .tests_done (tests_done),
        .errors     (errors)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("run timed out after %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    always @(posedge CLK) begin
        if (reset) begin
            grant_count <= 0;
            resp_count <= 0;
        end else begin
            grant_count <= grant_count + $countones(req_valid & req_ready);
            if (resp_valid) resp_count <= resp_count + 1;
        end
    end

    task automatic add_test(input logic [127:0] name, input int req, input logic write,
                            input int addr, input bus_types_pkg::word_t wdata, input int group);
        t_name[n_entries] = name;
        t_req[n_entries] = req;
        t_write[n_entries] = write;
        t_addr[n_entries] = bus_types_pkg::addr_t'(addr);
        t_wdata[n_entries] = wdata;
        t_group[n_entries] = group;
        n_entries++;
        if (group + 1 > n_groups) n_groups = group + 1;
    endtask

    task automatic build_table();
        n_entries = 0;
        n_groups = 0;
        add_test("rst_rd_a00", 0, 1'b0, 0, '0, 0);    // memory is clear after reset
        add_test("rst_rd_a11", 1, 1'b0, 17, '0, 0);
        add_test("rst_rd_a3f", 2, 1'b0, 63, '0, 0);
        add_test("rst_rd_a2a", 3, 1'b0, 42, '0, 0);
        add_test("wr_a0a_r1", 1, 1'b1, 10, $urandom(), 1);
        add_test("rd_a0a_r2", 2, 1'b0, 10, '0, 2);
        for (int r = 0; r < `NUM_REQUESTERS; r++) begin
            add_test({"rr_wr_r", 8'h30 + r[7:0]}, r, 1'b1, 20 + r, $urandom(), 3);
        end
        for (int r = 0; r < `NUM_REQUESTERS; r++) begin    // three back to back per requester
            add_test({"bst_wr_r", 8'h30 + r[7:0]}, r, 1'b1, 30 + r, $urandom(), 4);
            add_test({"bst_rd_r", 8'h30 + r[7:0]}, r, 1'b0, 30 + r, '0, 4);
            add_test({"bst_old_r", 8'h30 + r[7:0]}, r, 1'b0, 20 + r, '0, 4);
        end
        add_test("mix_wr40_r0", 0, 1'b1, 40, $urandom(), 5);
        add_test("mix_rd41_r0", 0, 1'b0, 41, '0, 5);
        add_test("mix_wr41_r1", 1, 1'b1, 41, $urandom(), 5);
        add_test("mix_rd40_r1", 1, 1'b0, 40, '0, 5);
        add_test("mix_wr40_r2", 2, 1'b1, 40, $urandom(), 5);
        add_test("mix_rd40_r2", 2, 1'b0, 40, '0, 5);
        add_test("mix_rd41_r3", 3, 1'b0, 41, '0, 5);
        add_test("mix_wr41_r3", 3, 1'b1, 41, $urandom(), 5);
    endtask

    task automatic present_request(input int r, input int idx);
        req_valid[r] <= 1'b1;
        req_write[r] <= t_write[idx];
        req_addr[r]  <= t_addr[idx];
        req_wdata[r] <= t_wdata[idx];
        req_name[r]  <= t_name[idx];
    endtask

    // each requester works through its own entries, the group ends when all responses are in
    task automatic run_group(input int g);
        int lane [`NUM_REQUESTERS][$];
        int cur [`NUM_REQUESTERS];
        bit busy;
        for (int i = 0; i < n_entries; i++) begin
            if (t_group[i] == g) lane[t_req[i]].push_back(i);
        end
        for (int r = 0; r < `NUM_REQUESTERS; r++) begin
            cur[r] = -1;
        end
        busy = 1'b1;
        while (busy) begin
            @(posedge CLK);
            busy = (req_valid != '0) || (grant_count != resp_count);
            for (int r = 0; r < `NUM_REQUESTERS; r++) begin
                if (cur[r] >= 0 && req_ready[r]) cur[r] = -1;    // taken at this edge
                if (cur[r] < 0 && lane[r].size() > 0) begin
                    cur[r] = lane[r].pop_front();
                    present_request(r, cur[r]);
                end else if (cur[r] < 0) begin
                    req_valid[r] <= 1'b0;
                end
                if (cur[r] >= 0) busy = 1'b1;
            end
        end
    endtask

    initial begin
        int assert_fails;
        bit missing;
        void'($urandom(87));
        reset = 1'b1;
        done = 1'b0;
        req_valid = '0;
        req_write = '0;
        for (int r = 0; r < `NUM_REQUESTERS; r++) begin
            req_addr[r] = '0;
            req_wdata[r] = '0;
            req_name[r] = '0;
        end
        build_table();
        repeat (4) @(posedge CLK);
        reset <= 1'b0;
        repeat (5) @(posedge CLK);    // idle, nothing may move
        for (int g = 0; g < n_groups; g++) begin
            run_group(g);
        end
        done <= 1'b1;
        repeat (2) @(posedge CLK);
        missing = (tests_done != n_entries);
        if (missing) begin
            $display("only %0d of %0d requests got a response", tests_done, n_entries);
        end
        assert_fails = dut_i.arb_i.arb_chk_i.assert_fails + dut_i.fifo_i.fifo_chk_i.assert_fails;
        if (assert_fails != 0) begin
            $display("%0d assertion failures in the bound checkers", assert_fails);
        end
        if (errors == 0 && !missing && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/bus_types_pkg.sv
logic/ctrl_pkg.sv
logic/req_link_if.sv
logic/request_arbiter.sv
logic/request_fifo.sv
logic/memory_controller.sv
logic/multicore_bus_top.sv
verif/bus_chk.sv
verif/bus_monitor.sv
verif/bus_tb.sv
